// ==== files.f ====
video_pkg.sv
video_ctrl.sv
video_timing.sv
clut_lookup.sv
videogen_top.sv
videogen_properties.sv
tb_videogen.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the videogen testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module tb_videogen -o tb_sim; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== tb_videogen.sv ====
`timescale 1ns/10ps

module tb_videogen;
	import video_pkg::*;

	// Handshake wait limit in cycles
	localparam int timeout_cycles = 50;

	logic clk_6md;
	logic rst_n;
	logic [7:0] pix_index;
	logic [11:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [11:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic sync;
	logic disp_en;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;

	// Shadow copies of the host-visible state
	logic [11:0] shadow_pal [0:511];
	logic [1:0] shadow_ctrl;

	// Pixel inputs seen at the last two edges
	logic [7:0] hist_idx0;
	logic [7:0] hist_idx1;
	logic hist_bank0;
	logic hist_bank1;
	logic hist_ven0;
	logic hist_ven1;

	logic check_armed;
	int mismatches;
	int failures;
	int timeouts;
	int lit_checks;
	string test_name;

	videogen_top dut0 (
		.clk_6md(clk_6md),
		.rst_n(rst_n),
		.pix_index(pix_index),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.sync(sync),
		.disp_en(disp_en),
		.red(red),
		.green(green),
		.blue(blue)
	);

	////////////////////////////////////////////////////////////
	// Clock and pixel source
	////////////////////////////////////////////////////////////

	// 100 ns period
	always #50 clk_6md = ~clk_6md;

	// New random index just after every rising edge
	always @(posedge clk_6md) begin
		#10;
		pix_index = 8'($urandom());
	end

	////////////////////////////////////////////////////////////
	// Reference model and comparison
	////////////////////////////////////////////////////////////

	// Bank bit on top of the index, black unless shown and enabled
	function automatic logic [11:0] expected_colour(input logic [11:0] pal [0:511],
			input logic bank_sel, input logic [7:0] idx, input logic ven, input logic enable);
		if (ven && enable) begin
			return pal[{bank_sel, idx}];
		end
		return 12'h000;
	endfunction

	// Sample inputs at the edge, check outputs half a cycle later
	always begin
		logic [11:0] exp_rgb;
		@(posedge clk_6md);
		hist_idx1 = hist_idx0;
		hist_bank1 = hist_bank0;
		hist_ven1 = hist_ven0;
		hist_idx0 = pix_index;
		hist_bank0 = shadow_ctrl[1];
		hist_ven0 = shadow_ctrl[0];
		@(negedge clk_6md);
		if (check_armed) begin
			// Colour now out was indexed one edge back
			exp_rgb = expected_colour(shadow_pal, hist_bank1, hist_idx1, hist_ven1, disp_en);
			if (disp_en && hist_ven1) begin
				lit_checks++;
			end
			assert ({blue, green, red} === exp_rgb) else begin
				mismatches++;
				$display("MISMATCH %s: expected %h, actual %h", test_name, exp_rgb,
					{blue, green, red});
			end
		end
	end

	////////////////////////////////////////////////////////////
	// AXI4-Lite master tasks
	////////////////////////////////////////////////////////////

	function automatic logic [11:0] entry_addr(input int entry);
		return pal_base + 12'(entry * 4);
	endfunction

	// Called and returns 10 ns after a rising edge
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
			input int hold_cycles);
		int n;
		int i;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while (!(awready && wready) && n < timeout_cycles) begin
			@(posedge clk_6md);
			#10;
			n++;
		end
		if (!(awready && wready)) begin
			timeouts++;
			$display("Timeout: write to %h was never accepted", addr);
		end
		// Transfer on this edge
		@(posedge clk_6md);
		#10;
		awvalid = 1'b0;
		wvalid = 1'b0;
		// Register or RAM took the word on that same edge
		if (addr[11]) begin
			shadow_pal[addr[10:2]] = data[11:0];
		end else if (addr == ctrl_addr) begin
			shadow_ctrl = data[1:0];
		end
		n = 0;
		while (!bvalid && n < timeout_cycles) begin
			@(posedge clk_6md);
			#10;
			n++;
		end
		if (!bvalid) begin
			timeouts++;
			$display("Timeout: no write response for %h", addr);
		end
		assert (bresp == 2'b00) else begin
			mismatches++;
			$display("MISMATCH %s bresp: expected 0, actual %h", test_name, bresp);
		end
		// Back-pressure on the response
		for (i = 0; i < hold_cycles; i++) begin
			@(posedge clk_6md);
			#10;
			assert (bvalid) else begin
				failures++;
				$display("Write response dropped while bready was held low");
			end
		end
		bready = 1'b1;
		@(posedge clk_6md);
		#10;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < timeout_cycles) begin
			@(posedge clk_6md);
			#10;
			n++;
		end
		if (!arready) begin
			timeouts++;
			$display("Timeout: read of %h was never accepted", addr);
		end
		@(posedge clk_6md);
		#10;
		arvalid = 1'b0;
		rready = 1'b1;
		n = 0;
		while (!rvalid && n < timeout_cycles) begin
			@(posedge clk_6md);
			#10;
			n++;
		end
		if (!rvalid) begin
			timeouts++;
			$display("Timeout: no read data for %h", addr);
		end
		data = rdata;
		resp = rresp;
		@(posedge clk_6md);
		#10;
		rready = 1'b0;
	endtask

	task automatic check_read(input logic [11:0] addr, input logic [31:0] exp_word);
		logic [31:0] got;
		logic [1:0] resp;
		axi_read(addr, got, resp);
		assert (got === exp_word) else begin
			mismatches++;
			$display("MISMATCH %s at %h: expected %h, actual %h", test_name, addr, exp_word, got);
		end
		assert (resp == 2'b00) else begin
			mismatches++;
			$display("MISMATCH %s rresp: expected 0, actual %h", test_name, resp);
		end
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			@(posedge clk_6md);
			#10;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Frame timing
	////////////////////////////////////////////////////////////

	// Long sync runs mark the first line of vertical sync
	task automatic check_frame_timing(input int nframes);
		int cyc;
		int rise_cyc;
		int last_rise;
		int run;
		int en_cnt;
		int seen;
		int limit;
		logic prev_sync;
		cyc = 0;
		rise_cyc = 0;
		last_rise = 0;
		run = 0;
		en_cnt = 0;
		seen = 0;
		limit = (nframes + 2) * h_total * v_total;
		prev_sync = sync;
		while (seen < nframes + 1 && cyc < limit) begin
			@(negedge clk_6md);
			cyc++;
			if (sync && !prev_sync) begin
				rise_cyc = cyc;
				run = 0;
			end
			if (sync) begin
				run++;
			end
			if (disp_en) begin
				en_cnt++;
			end
			// A pulse already running at the start has no rising edge
			if (!sync && prev_sync && rise_cyc > 0
					&& run > h_sync_end - h_sync_start) begin
				// First frame only starts the count
				if (seen > 0) begin
					assert (rise_cyc - last_rise == h_total * v_total) else begin
						mismatches++;
						$display("MISMATCH %s period: expected %0d, actual %0d", test_name,
							h_total * v_total, rise_cyc - last_rise);
					end
					assert (en_cnt == h_active * v_active) else begin
						mismatches++;
						$display("MISMATCH %s active: expected %0d, actual %0d", test_name,
							h_active * v_active, en_cnt);
					end
				end
				last_rise = rise_cyc;
				en_cnt = 0;
				seen++;
			end
			prev_sync = sync;
		end
		if (seen < nframes + 1) begin
			timeouts++;
			$display("Timeout: only %0d vertical sync pulses seen", seen);
		end
		@(posedge clk_6md);
		#10;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		int entry;
		int lit_before;
		logic [31:0] word;
		void'($urandom(32'h1490b367));
		clk_6md = 1'b0;
		rst_n = 1'b0;
		pix_index = 8'h00;
		awaddr = 12'h000;
		awvalid = 1'b0;
		wdata = 32'h0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 12'h000;
		arvalid = 1'b0;
		rready = 1'b0;
		shadow_ctrl = 2'b00;
		check_armed = 1'b0;
		mismatches = 0;
		failures = 0;
		timeouts = 0;
		lit_checks = 0;
		test_name = "reset";
		repeat (5) @(posedge clk_6md);
		#10;
		rst_n = 1'b1;
		@(posedge clk_6md);
		#10;
		assert (!awready && !wready && !arready && !bvalid && !rvalid) else begin
			failures++;
			$display("Bus handshake outputs not idle after reset");
		end
		check_armed = 1'b1;

		// Whole RAM gets a known colour first
		test_name = "palette_fill";
		for (i = 0; i < 512; i++) begin
			axi_write(entry_addr(i), $urandom(), 0);
		end

		test_name = "palette_readback";
		repeat (32) begin
			entry = int'($urandom_range(511, 0));
			axi_write(entry_addr(entry), $urandom(), 0);
		end
		repeat (48) begin
			entry = int'($urandom_range(511, 0));
			check_read(entry_addr(entry), {20'h0, shadow_pal[entry]});
		end

		// Upper bits are noise and read back as zero
		test_name = "ctrl_readback";
		for (i = 0; i < 4; i++) begin
			word = $urandom();
			word[1:0] = 2'(i);
			axi_write(ctrl_addr, word, 0);
			check_read(ctrl_addr, {30'h0, word[1:0]});
		end

		test_name = "bank0_lookup";
		axi_write(ctrl_addr, 32'h1, 0);
		lit_before = lit_checks;
		run_cycles(3 * h_total * v_total);
		assert (lit_checks > lit_before) else begin
			failures++;
			$display("No displayed pixels were checked with bank 0");
		end

		test_name = "bank1_lookup";
		axi_write(ctrl_addr, 32'h3, 0);
		lit_before = lit_checks;
		run_cycles(2 * h_total * v_total);
		assert (lit_checks > lit_before) else begin
			failures++;
			$display("No displayed pixels were checked with bank 1");
		end

		test_name = "video_disabled";
		axi_write(ctrl_addr, 32'h2, 0);
		run_cycles(h_total * v_total);

		test_name = "frame_timing";
		check_frame_timing(3);

		// Held response, then a normal write right after
		test_name = "backpressure";
		entry = int'($urandom_range(511, 0));
		axi_write(entry_addr(entry), $urandom(), 6);
		axi_write(entry_addr((entry + 1) % 512), $urandom(), 0);
		check_read(entry_addr(entry), {20'h0, shadow_pal[entry]});
		check_read(entry_addr((entry + 1) % 512), {20'h0, shadow_pal[(entry + 1) % 512]});

		$display("Summary: %0d mismatches, %0d other failures, %0d timeouts",
			mismatches, failures, timeouts);
		if (mismatches == 0 && failures == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== videogen_properties.sv ====
`timescale 1ns/10ps

module videogen_properties (
	input logic clk_6md,
	input logic rst_n,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic disp_en,
	input logic [3:0] red,
	input logic [3:0] green,
	input logic [3:0] blue
);

	////////////////////////////////////////////////////////////
	// Bus handshakes
	////////////////////////////////////////////////////////////

	// Response held until taken
	a_bvalid_hold: assert property (@(posedge clk_6md) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk_6md) disable iff (!rst_n)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// AW and W accepted as a pair
	a_ready_pair: assert property (@(posedge clk_6md) disable iff (!rst_n)
		($rose(awready) || $rose(wready)) |-> ($rose(awready) && $rose(wready)))
		else $error("awready and wready rose apart");

	////////////////////////////////////////////////////////////
	// Video output
	////////////////////////////////////////////////////////////

	// Black during blanking
	a_blank_black: assert property (@(posedge clk_6md) disable iff (!rst_n)
		!disp_en |-> (red == 4'h0 && green == 4'h0 && blue == 4'h0))
		else $error("colour present while disp_en low");

endmodule

// Bus checks on the slave, video checks on the lookup block
bind video_ctrl videogen_properties ctrl_props (
	.clk_6md(clk_6md),
	.rst_n(rst_n),
	.awready(awready),
	.wready(wready),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.disp_en(1'b1),
	.red(4'h0),
	.green(4'h0),
	.blue(4'h0)
);

bind clut_lookup videogen_properties clut_props (
	.clk_6md(clk_6md),
	.rst_n(rst_n),
	.awready(1'b0),
	.wready(1'b0),
	.bvalid(1'b0),
	.bready(1'b0),
	.rvalid(1'b0),
	.rready(1'b0),
	.disp_en(disp_en),
	.red(red),
	.green(green),
	.blue(blue)
);

// ==== videogen_top.sv ====
`timescale 1ns/10ps

module videogen_top (
	input  logic clk_6md,
	input  logic rst_n,
	input  logic [7:0] pix_index,
	// AXI4-Lite slave
	input  logic [11:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [11:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	// Video out
	output logic sync,
	output logic disp_en,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);
	import video_pkg::*;

	// Host side of the palette
	logic pal_we;
	logic [pal_addr_bits-1:0] pal_wr_addr;
	logic [11:0] pal_wr_data;
	logic [pal_addr_bits-1:0] pal_rd_addr;
	logic [11:0] pal_rd_data;

	// Control register fields
	logic bank;
	logic video_en;

	// Undelayed timing
	logic raw_sync;
	logic raw_en;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	video_ctrl u_ctrl (
		.clk_6md(clk_6md),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.pal_we(pal_we),
		.pal_wr_addr(pal_wr_addr),
		.pal_wr_data(pal_wr_data),
		.pal_rd_addr(pal_rd_addr),
		.pal_rd_data(pal_rd_data),
		.bank(bank),
		.video_en(video_en)
	);

	video_timing u_timing (
		.clk_6md(clk_6md),
		.rst_n(rst_n),
		.raw_sync(raw_sync),
		.raw_en(raw_en)
	);

	// Index to colour
	clut_lookup u_clut (
		.clk_6md(clk_6md),
		.rst_n(rst_n),
		.pix_index(pix_index),
		.bank(bank),
		.video_en(video_en),
		.raw_sync(raw_sync),
		.raw_en(raw_en),
		.pal_we(pal_we),
		.pal_wr_addr(pal_wr_addr),
		.pal_wr_data(pal_wr_data),
		.pal_rd_addr(pal_rd_addr),
		.pal_rd_data(pal_rd_data),
		.sync(sync),
		.disp_en(disp_en),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== clut_lookup.sv ====
`timescale 1ns/10ps

module clut_lookup (
	input  logic clk_6md,
	input  logic rst_n,
	// Pixel side
	input  logic [7:0] pix_index,
	input  logic bank,
	input  logic video_en,
	input  logic raw_sync,
	input  logic raw_en,
	// Host palette port
	input  logic pal_we,
	input  logic [video_pkg::pal_addr_bits-1:0] pal_wr_addr,
	input  logic [11:0] pal_wr_data,
	input  logic [video_pkg::pal_addr_bits-1:0] pal_rd_addr,
	output logic [11:0] pal_rd_data,
	// Video out
	output logic sync,
	output logic disp_en,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);
	import video_pkg::*;

	// Entry packs blue, green, red with red lowest
	logic [11:0] pal_mem [0:(1 << pal_addr_bits)-1];

	logic [7:0] idx_q;
	logic bank_q;
	logic ven_q;
	logic sync_q;
	logic en_q;

	////////////////////////////////////////////////////////////
	// Stage one latch
	////////////////////////////////////////////////////////////

	// Index and bank for the palette address
	always_ff @(posedge clk_6md) begin
		idx_q <= pix_index;
		bank_q <= bank;
	end

	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			ven_q <= 1'b0;
			sync_q <= 1'b0;
			en_q <= 1'b0;
		end else begin
			ven_q <= video_en;
			sync_q <= raw_sync;
			en_q <= raw_en;
		end
	end

	////////////////////////////////////////////////////////////
	// Palette RAM and colour registers
	////////////////////////////////////////////////////////////

	// Host write and host read port
	always_ff @(posedge clk_6md) begin
		if (pal_we) begin
			pal_mem[pal_wr_addr] <= pal_wr_data;
		end
		pal_rd_data <= pal_mem[pal_rd_addr];
	end

	// Bank bit on top of the index
	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			{blue, green, red} <= 12'h000;
		end else if (en_q && ven_q) begin
			{blue, green, red} <= pal_mem[{bank_q, idx_q}];
		end else begin
			// Black outside the active area
			{blue, green, red} <= 12'h000;
		end
	end

	// Second stage of the sync and enable delay
	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			sync <= 1'b0;
			disp_en <= 1'b0;
		end else begin
			sync <= sync_q;
			disp_en <= en_q;
		end
	end

endmodule

// ==== video_timing.sv ====
`timescale 1ns/10ps

module video_timing (
	input  logic clk_6md,
	input  logic rst_n,
	output logic raw_sync,
	output logic raw_en
);
	import video_pkg::*;

	logic [h_cnt_bits-1:0] h_cnt;
	logic [v_cnt_bits-1:0] v_cnt;
	logic h_last;
	logic v_last;
	logic h_in_sync;
	logic v_in_sync;

	////////////////////////////////////////////////////////////
	// Pixel and line counters
	////////////////////////////////////////////////////////////

	assign h_last = h_cnt == h_cnt_bits'(h_total - 1);
	assign v_last = v_cnt == v_cnt_bits'(v_total - 1);

	// Line counter steps once per wrap of the pixel counter
	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			if (v_last) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Raw sync and enable
	////////////////////////////////////////////////////////////

	// Active area starts at count zero
	assign raw_en = (h_cnt < h_cnt_bits'(h_active)) && (v_cnt < v_cnt_bits'(v_active));

	// Sync spans are half open
	assign h_in_sync = (h_cnt >= h_cnt_bits'(h_sync_start))
		&& (h_cnt < h_cnt_bits'(h_sync_end));
	assign v_in_sync = (v_cnt >= v_cnt_bits'(v_sync_start))
		&& (v_cnt < v_cnt_bits'(v_sync_end));

	// Whole lines of the vertical span read as sync
	assign raw_sync = h_in_sync | v_in_sync;

endmodule

// ==== video_ctrl.sv ====
`timescale 1ns/10ps

module video_ctrl (
	input  logic clk_6md,
	input  logic rst_n,
	// Write address channel
	input  logic [11:0] awaddr,
	input  logic awvalid,
	output logic awready,
	// Write data channel
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	// Write response channel
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	// Read address channel
	input  logic [11:0] araddr,
	input  logic arvalid,
	output logic arready,
	// Read data channel
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	// Palette host port
	output logic pal_we,
	output logic [video_pkg::pal_addr_bits-1:0] pal_wr_addr,
	output logic [11:0] pal_wr_data,
	output logic [video_pkg::pal_addr_bits-1:0] pal_rd_addr,
	input  logic [11:0] pal_rd_data,
	// Control register fields
	output logic bank,
	output logic video_en
);
	import video_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_wr_acc,
		st_wr_resp,
		st_rd_acc,
		st_rd_ram,
		st_rd_data,
		st_rd_resp
	} ctrl_state_e;

	ctrl_state_e state;

	reg_word_u wr_word;
	reg_word_u rd_word;
	logic wr_fire;
	logic rd_fire;
	logic wr_is_pal;
	logic wr_is_ctrl;
	logic rd_sel_pal;
	logic rd_sel_ctrl;

	////////////////////////////////////////////////////////////
	// Address decode and write data
	////////////////////////////////////////////////////////////

	// AW and W are taken on the same edge
	assign wr_fire = awvalid & awready & wvalid & wready;
	assign rd_fire = arvalid & arready;

	assign wr_is_pal = awaddr[11] == pal_base[11];
	assign wr_is_ctrl = awaddr == ctrl_addr;

	// Full-word writes only, byte strobes not decoded
	assign wr_word = wdata;

	// RAM write lands on the accepting edge
	assign pal_we = wr_fire & wr_is_pal;
	assign pal_wr_addr = awaddr[pal_addr_bits+1:2];
	assign pal_wr_data = {wr_word.colour.blue, wr_word.colour.green, wr_word.colour.red};

	// Always OKAY
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (!rst_n) begin
			state <= st_idle;
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			bank <= 1'b0;
			video_en <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// Writes win when both channels wait
					if (awvalid && wvalid) begin
						awready <= 1'b1;
						wready <= 1'b1;
						state <= st_wr_acc;
					end else if (arvalid) begin
						arready <= 1'b1;
						state <= st_rd_acc;
					end
				end
				st_wr_acc: begin
					if (wr_fire) begin
						awready <= 1'b0;
						wready <= 1'b0;
						bvalid <= 1'b1;
						state <= st_wr_resp;
						// Control view of the same word
						if (wr_is_ctrl) begin
							bank <= wr_word.ctrl.bank;
							video_en <= wr_word.ctrl.video_en;
						end
					end
				end
				st_wr_resp: begin
					// Hold until the master takes it
					if (bready) begin
						bvalid <= 1'b0;
						state <= st_idle;
					end
				end
				st_rd_acc: begin
					if (rd_fire) begin
						arready <= 1'b0;
						state <= st_rd_ram;
					end
				end
				// RAM samples the read address
				st_rd_ram: state <= st_rd_data;
				st_rd_data: begin
					rvalid <= 1'b1;
					state <= st_rd_resp;
				end
				st_rd_resp: begin
					if (rready) begin
						rvalid <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	// Read address and target captured at acceptance
	always_ff @(posedge clk_6md) begin
		if (rd_fire) begin
			pal_rd_addr <= araddr[pal_addr_bits+1:2];
			rd_sel_pal <= araddr[11] == pal_base[11];
			rd_sel_ctrl <= araddr == ctrl_addr;
		end
	end

	// Unmapped addresses read as zero
	always_comb begin
		rd_word = '0;
		if (rd_sel_pal) begin
			rd_word.colour.red = pal_rd_data[3:0];
			rd_word.colour.green = pal_rd_data[7:4];
			rd_word.colour.blue = pal_rd_data[11:8];
		end else if (rd_sel_ctrl) begin
			rd_word.ctrl.bank = bank;
			rd_word.ctrl.video_en = video_en;
		end
	end

	// Loaded together with rvalid
	always_ff @(posedge clk_6md) begin
		if (state == st_rd_data) begin
			rdata <= rd_word;
		end
	end

endmodule

// ==== video_pkg.sv ====
package video_pkg;

	////////////////////////////////////////////////////////////
	// Frame timing
	////////////////////////////////////////////////////////////

	// Horizontal spans in pixels
	localparam int h_active = 16;
	localparam int h_total = 24;
	localparam int h_sync_start = 18;
	localparam int h_sync_end = 20;

	// Vertical spans in lines
	localparam int v_active = 6;
	localparam int v_total = 9;
	localparam int v_sync_start = 7;
	localparam int v_sync_end = 8;

	// Counter widths for the timing generator
	localparam int h_cnt_bits = $clog2(h_total);
	localparam int v_cnt_bits = $clog2(v_total);

	////////////////////////////////////////////////////////////
	// Host address map
	////////////////////////////////////////////////////////////

	// Bank bit plus 8-bit index
	localparam int pal_addr_bits = 9;

	// Byte addresses; bit 11 picks the palette
	localparam logic [11:0] ctrl_addr = 12'h000;
	localparam logic [11:0] pal_base = 12'h800;

	// Bus data word, colour entry or control register
	typedef union packed {
		struct packed {
			logic [19:0] unused;
			logic [3:0] blue;
			logic [3:0] green;
			logic [3:0] red;
		} colour;
		struct packed {
			logic [29:0] unused;
			logic bank;
			logic video_en;
		} ctrl;
	} reg_word_u;

endpackage
